/* cachePkg.sv */
/* Shared widths, word and address types, and the controller state encoding.
   Imported by every cache module that names one of them. */
package cachePkg;

  localparam int dataWidth = 32;
  localparam int addrWidth = 32;

  typedef logic [dataWidth-1:0] wordT;
  typedef logic [addrWidth-1:0] addrT;

  ////////////////////
  // controller states
  ////////////////////
  typedef enum logic [3:0] {
    ready,
    // miss handling
    missFetch,
    missFetchDone,
    missEvict,
    missWriteLine,
    missWord,
    // flush walk
    flushStart,
    flushCheck,
    flushIncr,
    flushWriteBack,
    flushClearDirty
  } cacheStateT;

endpackage

/* arrayCtrlIf.sv */
/* Strobes from the cache controller to the tag/data array and the status it returns.
   The controller drives one side, the array the other. */
`timescale 1ns/1ps

interface arrayCtrlIf
  import cachePkg::*;
();
  // controller to array
  logic lineWriteEn;
  logic wordWriteEn;
  logic setDirty;
  logic clearDirty;
  logic lruWriteEn;
  logic selFlush;
  cacheStateT state;
  // array to controller
  logic hit;
  logic victimDirty;

  modport controller (
    output lineWriteEn, wordWriteEn, setDirty, clearDirty, lruWriteEn, selFlush, state,
    input  hit, victimDirty
  );

  modport array (
    input  lineWriteEn, wordWriteEn, setDirty, clearDirty, lruWriteEn, selFlush, state,
    output hit, victimDirty
  );

endinterface

/* cacheFsm.sv */
/* Cache controller. Sequences hits, line fetch, dirty eviction and the full flush walk,
   and decodes every array, counter and bus strobe from the current state. */
`timescale 1ns/1ps

module cacheFsm
  import cachePkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic reqValid,
  input  logic reqWrite,
  input  logic flushReq,
  input  logic lineDone,
  input  logic lastSet,
  input  logic lastWay,
  output logic respValid,
  output logic busy,
  output logic flushDone,
  output logic fetchLine,
  output logic writeLine,
  output logic adrCntEn,
  output logic wayCntEn,
  output logic adrCntRst,
  output logic wayCntRst,
  arrayCtrlIf.controller arr
);

  cacheStateT state, nextState;
  logic doReq, doFlush, doHit, doMiss;
  logic flushEnd;

  // a request answered last cycle is still on the port, so it is not new
  assign doReq   = reqValid & ~respValid;
  assign doFlush = flushReq & ~flushDone;
  assign doHit   = doReq & arr.hit;
  assign doMiss  = doReq & ~arr.hit;
  assign flushEnd = lastSet & lastWay;

  ////////////////////
  // state register
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = ready;
    case (state)
      ready: begin
        if (doFlush) nextState = flushStart;
        else if (doMiss) nextState = missFetch;
        else nextState = ready;
      end
      missFetch: nextState = lineDone ? missFetchDone : missFetch;
      missFetchDone: nextState = arr.victimDirty ? missEvict : missWriteLine;
      missEvict: nextState = lineDone ? missWriteLine : missEvict;
      missWriteLine: nextState = missWord;
      missWord: nextState = ready;
      flushStart: nextState = flushCheck;
      flushCheck: begin
        if (arr.victimDirty) nextState = flushWriteBack;
        else if (flushEnd) nextState = ready;
        else if (lastWay) nextState = flushIncr;
        else nextState = flushCheck;
      end
      flushIncr: nextState = flushCheck;
      flushWriteBack: nextState = lineDone ? flushClearDirty : flushWriteBack;
      flushClearDirty: begin
        if (flushEnd) nextState = ready;
        else if (lastWay) nextState = flushIncr;
        else nextState = flushCheck;
      end
      default: nextState = ready;
    endcase
  end

  // registered one-cycle responses to the CPU
  always_ff @(posedge clk) begin
    if (reset) begin
      respValid <= 1'b0;
      flushDone <= 1'b0;
    end else begin
      respValid <= (state == ready & doHit & ~doFlush) | (state == missWord);
      flushDone <= (state == flushCheck & ~arr.victimDirty & flushEnd) |
                   (state == flushClearDirty & flushEnd);
    end
  end

  assign busy = (state != ready) | doFlush | doMiss;

  ////////////////////
  // array strobes
  ////////////////////
  assign arr.state       = state;
  assign arr.lineWriteEn = (state == missWriteLine);
  assign arr.wordWriteEn = (state == ready & doHit & reqWrite) | (state == missWord & reqWrite);
  assign arr.setDirty    = arr.wordWriteEn;
  // the new line goes in clean, and a written-back line is clean again
  assign arr.clearDirty  = (state == missWriteLine) | (state == flushClearDirty);
  assign arr.lruWriteEn  = (state == ready & doHit) | (state == missWord);
  assign arr.selFlush    = (state == flushStart) | (state == flushCheck) |
                           (state == flushIncr) | (state == flushWriteBack) |
                           (state == flushClearDirty);

  // flush walk counters
  assign adrCntEn  = (state == flushCheck & ~arr.victimDirty & lastWay & ~lastSet) |
                     (state == flushClearDirty & lastWay & ~lastSet);
  assign wayCntEn  = (state == flushCheck & ~arr.victimDirty & ~flushEnd) |
                     (state == flushClearDirty & ~flushEnd);
  assign adrCntRst = (state == ready & doFlush);
  assign wayCntRst = (state == ready & doFlush) | (state == flushIncr);

  // line transfers on the bus
  assign fetchLine = (state == ready & doMiss & ~doFlush);
  assign writeLine = (state == missFetchDone & arr.victimDirty) |
                     (state == flushCheck & arr.victimDirty);

endmodule

/* flushCounter.sv */
/* Set and way counters for the flush walk, with the terminal flags the controller
   uses to step to the next set and to end the flush. */
`timescale 1ns/1ps

module flushCounter #(
  parameter int numSets = 8
) (
  input  logic clk,
  input  logic reset,
  input  logic adrCntEn,
  input  logic wayCntEn,
  input  logic adrCntRst,
  input  logic wayCntRst,
  output logic [$clog2(numSets)-1:0] flushSet,
  output logic flushWay,
  output logic lastSet,
  output logic lastWay
);

  localparam int setBits = $clog2(numSets);

  always_ff @(posedge clk) begin
    if (reset | adrCntRst) begin
      flushSet <= '0;
    end else if (adrCntEn) begin
      flushSet <= flushSet + 1'b1;
    end
  end

  // two ways, so the way counter is a toggle
  always_ff @(posedge clk) begin
    if (reset | wayCntRst) begin
      flushWay <= 1'b0;
    end else if (wayCntEn) begin
      flushWay <= ~flushWay;
    end
  end

  assign lastSet = (flushSet == setBits'(numSets - 1));
  assign lastWay = flushWay;

endmodule

/* cacheArray.sv */
/* Two-way tag, state and data storage. Forms the hit, picks the victim way and feeds
   the bus master with the victim line; a fill buffer collects the fetched line. */
`timescale 1ns/1ps

module cacheArray
  import cachePkg::*;
#(
  parameter int numSets      = 8,
  parameter int wordsPerLine = 4
) (
  input  logic clk,
  input  logic reset,
  arrayCtrlIf.array ctrl,
  input  addrT reqAddr,
  input  wordT reqWdata,
  input  logic [$clog2(numSets)-1:0] flushSet,
  input  logic flushWay,
  input  wordT fillWord,
  input  logic [$clog2(wordsPerLine)-1:0] fillIndex,
  input  logic fillEn,
  output wordT rdata,
  output wordT victimWord,
  output addrT victimAddr
);

  localparam int setBits  = $clog2(numSets);
  localparam int offBits  = $clog2(wordsPerLine);
  localparam int tagWidth = addrWidth - setBits - offBits - 2;

  logic [tagWidth-1:0] tags [2][numSets];
  wordT lines [2][numSets][wordsPerLine];
  wordT fillBuf [wordsPerLine];
  logic [1:0] validBits [numSets];
  logic [1:0] dirtyBits [numSets];
  logic [numSets-1:0] lruBits;

  logic [tagWidth-1:0] reqTag;
  logic [setBits-1:0] reqSet, curSet;
  logic [offBits-1:0] reqWord;
  logic [1:0] wayHit;
  logic hitWay, victimWay;

  // address fields
  assign reqTag  = reqAddr[addrWidth-1 -: tagWidth];
  assign reqSet  = reqAddr[offBits+2 +: setBits];
  assign reqWord = reqAddr[2 +: offBits];
  assign curSet  = ctrl.selFlush ? flushSet : reqSet;

  ////////////////////
  // lookup
  ////////////////////
  assign wayHit[0] = validBits[curSet][0] & (tags[0][curSet] == reqTag);
  assign wayHit[1] = validBits[curSet][1] & (tags[1][curSet] == reqTag);
  assign ctrl.hit  = |wayHit;
  assign hitWay    = wayHit[1];
  assign rdata     = lines[hitWay][reqSet][reqWord];

  // an empty way is filled first, otherwise the LRU way goes
  always_comb begin
    if (ctrl.selFlush) victimWay = flushWay;
    else if (!validBits[curSet][0]) victimWay = 1'b0;
    else if (!validBits[curSet][1]) victimWay = 1'b1;
    else victimWay = lruBits[curSet];
  end

  assign ctrl.victimDirty = validBits[curSet][victimWay] & dirtyBits[curSet][victimWay];
  assign victimAddr = {tags[victimWay][curSet], curSet, {(offBits + 2){1'b0}}};
  assign victimWord = lines[victimWay][curSet][fillIndex];

  ////////////////////
  // state bits
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < numSets; i++) begin
        validBits[i] <= 2'b00;
        dirtyBits[i] <= 2'b00;
      end
      lruBits <= '0;
    end else begin
      if (ctrl.lineWriteEn) validBits[curSet][victimWay] <= 1'b1;
      if (ctrl.clearDirty) dirtyBits[curSet][victimWay] <= 1'b0;
      if (ctrl.setDirty) dirtyBits[curSet][hitWay] <= 1'b1;
      // point at the way that was not just used
      if (ctrl.lruWriteEn) lruBits[curSet] <= ~hitWay;
    end
  end

  // tags, lines and fill buffer
  always_ff @(posedge clk) begin
    if (fillEn) fillBuf[fillIndex] <= fillWord;
    if (ctrl.lineWriteEn) begin
      lines[victimWay][curSet] <= fillBuf;
      tags[victimWay][curSet] <= reqTag;
    end
    if (ctrl.wordWriteEn) lines[hitWay][curSet][reqWord] <= reqWdata;
  end

endmodule

/* lineBusMaster.sv */
/* AXI4-Lite master that moves one cache line as one single-word transaction per word,
   in address order, for line fetch and for write-back of the victim line. */
`timescale 1ns/1ps

module lineBusMaster
  import cachePkg::*;
#(
  parameter int wordsPerLine = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic fetchLine,
  input  logic writeLine,
  input  addrT fetchAddr,
  input  addrT victimAddr,
  input  wordT victimWord,
  output wordT fillWord,
  output logic [$clog2(wordsPerLine)-1:0] fillIndex,
  output logic fillEn,
  output logic lineDone,
  output logic awvalid,
  input  logic awready,
  output addrT awaddr,
  output logic wvalid,
  input  logic wready,
  output wordT wdata,
  input  logic bvalid,
  output logic bready,
  output logic arvalid,
  input  logic arready,
  output addrT araddr,
  input  logic rvalid,
  output logic rready,
  input  wordT rdata
);

  localparam int offBits = $clog2(wordsPerLine);

  typedef enum logic [2:0] {idle, rdAddr, rdData, wrAddr, wrResp} busStateT;

  busStateT busState;
  logic [offBits-1:0] beat;
  addrT baseAddr, beatAddr;
  logic awDone, wDone, awFire, wFire, lastBeat;

  assign lastBeat = (beat == offBits'(wordsPerLine - 1));
  assign beatAddr = baseAddr | addrT'({beat, 2'b00});

  // channel outputs
  assign arvalid = (busState == rdAddr);
  assign araddr  = beatAddr;
  assign rready  = (busState == rdData);
  assign awvalid = (busState == wrAddr) & ~awDone;
  assign wvalid  = (busState == wrAddr) & ~wDone;
  assign awaddr  = beatAddr;
  assign wdata   = victimWord;
  assign bready  = (busState == wrResp);
  assign awFire  = awvalid & awready;
  assign wFire   = wvalid & wready;

  // the beat index also selects the victim word in the array
  assign fillWord  = rdata;
  assign fillIndex = beat;
  assign fillEn    = rready & rvalid;
  assign lineDone  = (fillEn | (bready & bvalid)) & lastBeat;

  ////////////////////
  // channel sequencing
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      busState <= idle;
      beat <= '0;
      awDone <= 1'b0;
      wDone <= 1'b0;
    end else begin
      case (busState)
        idle: begin
          beat <= '0;
          if (fetchLine) busState <= rdAddr;
          else if (writeLine) busState <= wrAddr;
        end
        rdAddr: if (arready) busState <= rdData;
        rdData: begin
          if (rvalid) begin
            busState <= lastBeat ? idle : rdAddr;
            beat <= beat + 1'b1;
          end
        end
        wrAddr: begin
          // address and data may be taken in different cycles
          if ((awDone | awFire) & (wDone | wFire)) begin
            busState <= wrResp;
            awDone <= 1'b0;
            wDone <= 1'b0;
          end else begin
            awDone <= awDone | awFire;
            wDone <= wDone | wFire;
          end
        end
        wrResp: begin
          if (bvalid) begin
            busState <= lastBeat ? idle : wrAddr;
            beat <= beat + 1'b1;
          end
        end
        default: busState <= idle;
      endcase
    end
  end

  // line base address
  always_ff @(posedge clk) begin
    if (busState == idle) begin
      if (fetchLine) baseAddr <= fetchAddr & ~addrT'(wordsPerLine * 4 - 1);
      else if (writeLine) baseAddr <= victimAddr;
    end
  end

endmodule

/* dataCache.sv */
/* Top level of the two-way write-back data cache. Connects the controller, flush
   counters, array and AXI4-Lite line master to the CPU and memory ports. */
`timescale 1ns/1ps

module dataCache
  import cachePkg::*;
#(
  parameter int numSets      = 8,
  parameter int wordsPerLine = 4
) (
  input  logic clk,
  input  logic reset,
  // CPU side
  input  logic reqValid,
  input  logic reqWrite,
  input  addrT reqAddr,
  input  wordT reqWdata,
  input  logic flushReq,
  output logic respValid,
  output wordT respRdata,
  output logic busy,
  output logic flushDone,
  // memory side
  output logic awvalid,
  input  logic awready,
  output addrT awaddr,
  output logic wvalid,
  input  logic wready,
  output wordT wdata,
  input  logic bvalid,
  output logic bready,
  output logic arvalid,
  input  logic arready,
  output addrT araddr,
  input  logic rvalid,
  output logic rready,
  input  wordT rdata
);

  logic fetchLine, writeLine, lineDone, fillEn;
  logic adrCntEn, wayCntEn, adrCntRst, wayCntRst;
  logic lastSet, lastWay, flushWay;
  logic [$clog2(numSets)-1:0] flushSet;
  logic [$clog2(wordsPerLine)-1:0] fillIndex;
  wordT fillWord, victimWord;
  addrT victimAddr;

  arrayCtrlIf arrCtrl ();

  cacheFsm fsm0 (
    .clk, .reset, .reqValid, .reqWrite, .flushReq,
    .lineDone, .lastSet, .lastWay,
    .respValid, .busy, .flushDone, .fetchLine, .writeLine,
    .adrCntEn, .wayCntEn, .adrCntRst, .wayCntRst,
    .arr(arrCtrl.controller)
  );

  flushCounter #(.numSets(numSets)) flushCnt0 (
    .clk, .reset, .adrCntEn, .wayCntEn, .adrCntRst, .wayCntRst,
    .flushSet, .flushWay, .lastSet, .lastWay
  );

  cacheArray #(.numSets(numSets), .wordsPerLine(wordsPerLine)) array0 (
    .clk, .reset, .ctrl(arrCtrl.array), .reqAddr, .reqWdata,
    .flushSet, .flushWay, .fillWord, .fillIndex, .fillEn,
    .rdata(respRdata), .victimWord, .victimAddr
  );

  // the bus master aligns the request address to its line
  lineBusMaster #(.wordsPerLine(wordsPerLine)) bus0 (
    .clk, .reset, .fetchLine, .writeLine, .fetchAddr(reqAddr), .victimAddr, .victimWord,
    .fillWord, .fillIndex, .fillEn, .lineDone,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .bvalid, .bready,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata
  );

endmodule

/* dataCache_properties.sv */
/* Assertions bound into the cache top. They cover AXI valid hold with stable payload
   and the one-cycle CPU response. */
`timescale 1ns/1ps

module dataCache_properties
  import cachePkg::*;
(
  input logic clk,
  input logic reset,
  input logic awvalid,
  input logic awready,
  input addrT awaddr,
  input logic wvalid,
  input logic wready,
  input wordT wdata,
  input logic arvalid,
  input logic arready,
  input addrT araddr,
  input logic respValid,
  input cacheStateT ctrlState
);

  int failures = 0;

  // a valid that is not taken stays up with the same payload
  awHold: assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      $error("write address valid dropped or changed before acceptance");
      failures++;
    end

  wHold: assert property (@(posedge clk) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata))
    else begin
      $error("write data valid dropped or changed before acceptance");
      failures++;
    end

  arHold: assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
      $error("read address valid dropped or changed before acceptance");
      failures++;
    end

  respPulse: assert property (@(posedge clk) disable iff (reset)
    respValid |=> !respValid)
    else begin
      $error("respValid high for two cycles in a row");
      failures++;
    end

  // the response comes out once the controller is back in ready
  respReady: assert property (@(posedge clk) disable iff (reset)
    respValid |-> ctrlState == ready)
    else begin
      $error("respValid while the controller is not in ready");
      failures++;
    end

endmodule

bind dataCache dataCache_properties props0 (
  .clk, .reset,
  .awvalid, .awready, .awaddr,
  .wvalid, .wready, .wdata,
  .arvalid, .arready, .araddr,
  .respValid,
  .ctrlState(arrCtrl.state)
);

/* axiMemModel.sv */
/* AXI4-Lite slave memory for the cache testbench. It takes one transaction at a time and
   answers after a random delay of up to three cycles. The testbench fills it before reset ends. */
`timescale 1ns/1ps

module axiMemModel
  import cachePkg::*;
#(
  parameter int memWords = 1024
) (
  input  logic clk,
  input  logic reset,
  input  logic awvalid,
  output logic awready,
  input  addrT awaddr,
  input  logic wvalid,
  output logic wready,
  input  wordT wdata,
  output logic bvalid,
  input  logic bready,
  input  logic arvalid,
  output logic arready,
  input  addrT araddr,
  output logic rvalid,
  input  logic rready,
  output wordT rdata
);

  localparam int idxBits = $clog2(memWords);

  typedef enum logic [2:0] {memIdle, memRdResp, memRdDone, memWrResp, memWrDone} memPhaseT;

  wordT store [memWords];
  memPhaseT phase;
  int holdCnt;
  integer delaySeed = 32'h084f_9200;

  // everything moves on the falling edge, when the master's signals have settled
  initial begin
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    arready = 1'b0;
    rvalid = 1'b0;
    rdata = '0;
    phase = memIdle;
    holdCnt = 0;
    forever begin
      @(negedge clk);
      // ready is up for one cycle only, exactly when a transfer is taken
      awready <= 1'b0;
      wready <= 1'b0;
      arready <= 1'b0;
      if (reset) begin
        bvalid <= 1'b0;
        rvalid <= 1'b0;
        phase <= memIdle;
        holdCnt <= 0;
      end else if (holdCnt != 0) begin
        holdCnt <= holdCnt - 1;
      end else begin
        case (phase)
          memIdle: begin
            if (arvalid) begin
              arready <= 1'b1;
              rdata <= store[araddr[2 +: idxBits]];
              phase <= memRdResp;
              holdCnt <= $random(delaySeed) & 3;
            end else if (awvalid && wvalid) begin
              awready <= 1'b1;
              wready <= 1'b1;
              store[awaddr[2 +: idxBits]] <= wdata;
              phase <= memWrResp;
              holdCnt <= $random(delaySeed) & 3;
            end
          end
          // rready is stable here, so it tells whether the next edge takes the beat
          memRdResp: begin
            rvalid <= 1'b1;
            if (rready) phase <= memRdDone;
          end
          memRdDone: begin
            rvalid <= 1'b0;
            phase <= memIdle;
            holdCnt <= $random(delaySeed) & 3;
          end
          memWrResp: begin
            bvalid <= 1'b1;
            if (bready) phase <= memWrDone;
          end
          default: begin
            bvalid <= 1'b0;
            phase <= memIdle;
            holdCnt <= $random(delaySeed) & 3;
          end
        endcase
      end
    end
  end

endmodule

/* dataCacheTb.sv */
/* Testbench for the two-way data cache. Directed hit, miss, eviction and flush cases
   and a seeded random mix run against a shadow image of memory. */
`timescale 1ns/1ps

module dataCacheTb
  import cachePkg::*;
();

  localparam int numSets      = 8;
  localparam int wordsPerLine = 4;
  localparam int memWords     = 1024;
  localparam int memIdxBits   = $clog2(memWords);
  localparam int accessLimit  = 500;
  localparam int flushLimit   = 5000;
  localparam wordT initXor    = 32'h5a3c_96e1;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic reqValid, reqWrite, flushReq;
  addrT reqAddr;
  wordT reqWdata, respRdata;
  logic respValid, busy, flushDone;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  addrT awaddr, araddr;
  wordT wdata, rdata;

  wordT shadow [memWords];
  addrT expWrites [$];
  logic trackWrites;
  string testName;
  integer seed = 32'h084f_9200;

  dataCache #(.numSets(numSets), .wordsPerLine(wordsPerLine)) dut0 (.*);
  axiMemModel #(.memWords(memWords)) mem0 (.*);

  always #10 clk = ~clk;

  // untouched memory holds its own address, scrambled
  function automatic wordT refInit(addrT addr);
    return addr ^ initXor;
  endfunction

  function automatic int wordIndex(addrT addr);
    return int'(addr[2 +: memIdxBits]);
  endfunction

  ////////////////////
  // checks
  ////////////////////
  task automatic stopWithError(input string why);
    $display("%s, during %s", why, testName);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkWord(input string what, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      $display("FAIL %s, %s: expected %h, actual %h", testName, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic checkAddr(input string what, input addrT expected, input addrT actual);
    if (actual !== expected) begin
      $display("FAIL %s, %s: expected %h, actual %h", testName, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "address mismatch");
    end
  endtask

  task automatic checkFlag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAIL %s, %s: expected %b, actual %b", testName, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic checkCycles(input string what, input int expected, input int actual);
    if (actual != expected) begin
      $display("FAIL %s, %s: expected %0d, actual %0d", testName, what, expected, actual);
      $display("Test FAILED");
      $fatal(1, "latency mismatch");
    end
  endtask

  // every write-back must carry the CPU's latest data
  always @(posedge clk) begin
    if (!reset && awvalid && awready && wvalid && wready) begin
      if (trackWrites) begin
        if (expWrites.size() == 0) stopWithError("write-back of a line that was not dirty");
        checkAddr("write-back address", expWrites.pop_front(), awaddr);
      end
      checkWord("write-back data", shadow[wordIndex(awaddr)], wdata);
    end
  end

  ////////////////////
  // CPU side
  ////////////////////
  task automatic cpuAccess(input logic write, input addrT addr, input wordT data,
                           output wordT rd, output int cycles);
    @(negedge clk);
    reqValid = 1'b1;
    reqWrite = write;
    reqAddr = addr;
    reqWdata = data;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > accessLimit) stopWithError("timeout, no response to a CPU request");
      // busy while the access is still open, idle again with the response
      checkFlag("busy during access", ~respValid, busy);
    end while (!respValid);
    rd = respRdata;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    if (write) shadow[wordIndex(addr)] = data;
  endtask

  task automatic readExpect(input string what, input addrT addr);
    wordT rd;
    int cycles;
    cpuAccess(1'b0, addr, '0, rd, cycles);
    checkWord(what, shadow[wordIndex(addr)], rd);
  endtask

  task automatic runFlush();
    int cycles;
    @(negedge clk);
    flushReq = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > flushLimit) stopWithError("timeout, flush never signalled flushDone");
      checkFlag("busy during flush", ~flushDone, busy);
    end while (!flushDone);
    flushReq = 1'b0;
  endtask

  initial begin
    wordT rd;
    int cycles;
    addrT addr;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    reqWdata = '0;
    flushReq = 1'b0;
    trackWrites = 1'b0;
    testName = "reset";
    for (int i = 0; i < memWords; i++) begin
      mem0.store[i] = refInit(addrT'(i * 4));
      shadow[i] = refInit(addrT'(i * 4));
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (respValid || flushDone || busy || awvalid || wvalid || arvalid || bready || rready)
      stopWithError("an output is active right after reset");

    testName = "read miss then hit";
    cpuAccess(1'b0, 32'h0000_0040, '0, rd, cycles);
    checkWord("miss data", refInit(32'h0000_0040), rd);
    cpuAccess(1'b0, 32'h0000_0040, '0, rd, cycles);
    checkWord("hit data", refInit(32'h0000_0040), rd);
    checkCycles("hit latency", 1, cycles);

    testName = "write then read";
    cpuAccess(1'b1, 32'h0000_0048, 32'hc0de_1234, rd, cycles);
    readExpect("read after write", 32'h0000_0048);

    testName = "dirty eviction";
    // three lines of set 0, the third pushes the LRU line out
    cpuAccess(1'b1, 32'h0000_0004, 32'h1111_aaaa, rd, cycles);
    cpuAccess(1'b1, 32'h0000_0084, 32'h2222_bbbb, rd, cycles);
    readExpect("third line", 32'h0000_0108);
    readExpect("first evicted word", 32'h0000_0004);
    readExpect("second evicted word", 32'h0000_0084);

    testName = "flush";
    runFlush();
    // one dirty line in each of sets 1 to 3, walked in set order
    for (int l = 1; l <= 3; l++) begin
      for (int w = 0; w < 2; w++) begin
        addr = 32'h0000_0200 + l * 16 + w * 4;
        cpuAccess(1'b1, addr, 32'hf100_0000 | addr, rd, cycles);
      end
      for (int w = 0; w < wordsPerLine; w++) expWrites.push_back(32'h0000_0200 + l * 16 + w * 4);
    end
    trackWrites = 1'b1;
    runFlush();
    if (expWrites.size() != 0) stopWithError("flush ended before every dirty word was written");
    trackWrites = 1'b0;

    testName = "random mix";
    repeat (200) begin
      addr = addrT'($random(seed)) & 32'h0000_03fc;
      if ($random(seed) & 1) cpuAccess(1'b1, addr, wordT'($random(seed)), rd, cycles);
      else readExpect("random read", addr);
    end

    @(negedge clk);
    if (dut0.props0.failures != 0) begin
      $display("Test FAILED");
      $fatal(1, "bound assertions failed %0d times", dut0.props0.failures);
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* sources.f */
cachePkg.sv
arrayCtrlIf.sv
cacheFsm.sv
flushCounter.sv
cacheArray.sv
lineBusMaster.sv
dataCache.sv
dataCache_properties.sv
axiMemModel.sv
dataCacheTb.sv

/* Bender.yml */
package:
  name: data_cache

sources:
  - cachePkg.sv
  - arrayCtrlIf.sv
  - cacheFsm.sv
  - flushCounter.sv
  - cacheArray.sv
  - lineBusMaster.sv
  - dataCache.sv
  - target: test
    files:
      - dataCache_properties.sv
      - axiMemModel.sv
      - dataCacheTb.sv
